//--- src/vmod_pkg.sv
package vmod_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////////

  // APB byte address and data word
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  localparam apb_addr_t REG_CTRL     = 8'h00;
  localparam apb_addr_t REG_MODULO   = 8'h04;
  localparam apb_addr_t REG_SIZE     = 8'h08;
  localparam apb_addr_t REG_DATA_IN  = 8'h0C;
  localparam apb_addr_t REG_DATA_OUT = 8'h10;
  localparam apb_addr_t REG_STATUS   = 8'h14;

  // Bit positions inside CTRL and STATUS
  localparam int CTRL_START_BIT  = 0;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

  // Scalar remainder FSM
  typedef enum logic {IDLE, SHIFT} scalar_state_t;

  // Vector sequencer FSM
  typedef enum logic [1:0] {STARTER, INPUT, COMPUTE, OUTPUT} vector_state_t;

endpackage

//--- src/scalar_mod.sv
`timescale 1ns/1ps

module scalar_mod
  import vmod_pkg::*;
#(
  parameter int DATA_W = 32
) (
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  logic [DATA_W-1:0] modulo,
  input  logic [DATA_W-1:0] data_in,
  output logic              ready,
  output logic [DATA_W-1:0] data_out
);

  // Counter still one bit wide when DATA_W is 1
  localparam int               CNT_W    = $clog2(DATA_W + 1);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_W - 1);

  scalar_state_t     state_q;
  logic [CNT_W-1:0]  bit_cnt_q;

  // Operands and partial remainder
  logic [DATA_W-1:0] dividend_q;
  logic [DATA_W-1:0] divisor_q;
  logic [DATA_W-1:0] rem_q;

  // Trial value, one bit wider than an operand
  logic [DATA_W:0]   trial;
  logic              subtract;
  logic [DATA_W-1:0] rem_next;

  // One restoring step, next dividend bit shifted in from the top
  always_comb begin
    trial    = {rem_q, dividend_q[DATA_W-1]};
    // Zero modulus never subtracts, so the element passes through
    subtract = (divisor_q != '0) && (trial >= {1'b0, divisor_q});
    if (subtract) begin
      rem_next = DATA_W'(trial - {1'b0, divisor_q});
    end else begin
      rem_next = trial[DATA_W-1:0];
    end
  end

  // Control, one step per cycle in SHIFT
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
      ready     <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start) begin
            bit_cnt_q <= '0;
            state_q   <= SHIFT;
          end
        end
        SHIFT: begin
          // Last dividend bit consumed, result valid with ready
          if (bit_cnt_q == LAST_BIT) begin
            ready   <= 1'b1;
            state_q <= IDLE;
          end else begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (state_q == IDLE && start) begin
      dividend_q <= data_in;
      divisor_q  <= modulo;
      rem_q      <= '0;
    end else if (state_q == SHIFT) begin
      dividend_q <= dividend_q << 1;
      rem_q      <= rem_next;
      if (bit_cnt_q == LAST_BIT) begin
        data_out <= rem_next;
      end
    end
  end

endmodule

//--- src/vector_mod.sv
`timescale 1ns/1ps

module vector_mod
  import vmod_pkg::*;
#(
  parameter int DATA_W  = 32,
  parameter int INDEX_W = 16
) (
  input  logic               CLK,
  input  logic               RST,
  input  logic               start,
  output logic               ready,
  input  logic [INDEX_W-1:0] size,
  input  logic [DATA_W-1:0]  modulo,
  input  logic [DATA_W-1:0]  data_in,
  input  logic               data_in_enable,
  output logic               in_ready,
  output logic [DATA_W-1:0]  data_out,
  output logic               data_out_enable,
  input  logic               out_ready
);

  vector_state_t      state_q;
  logic [INDEX_W-1:0] index_q;
  logic [INDEX_W-1:0] last_index;

  // Scalar unit handshake
  logic               start_scalar;
  logic               ready_scalar;
  logic [DATA_W-1:0]  modulo_scalar;
  logic [DATA_W-1:0]  data_scalar;
  logic [DATA_W-1:0]  data_out_scalar;

  // Zero length runs one element
  assign last_index = (size == '0) ? '0 : size - 1'b1;

  // Element accepted only while waiting for input
  assign in_ready = (state_q == INPUT);

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q         <= STARTER;
      index_q         <= '0;
      start_scalar    <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
    end else begin
      // Pulses default low
      start_scalar    <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
      case (state_q)
        STARTER: begin
          if (start) begin
            index_q <= '0;
            state_q <= INPUT;
          end
        end
        INPUT: begin
          if (data_in_enable) begin
            start_scalar <= 1'b1;
            state_q      <= COMPUTE;
          end
        end
        COMPUTE: begin
          if (ready_scalar) begin
            state_q <= OUTPUT;
          end
        end
        OUTPUT: begin
          // Hold the result until the slot is free
          if (out_ready) begin
            data_out_enable <= 1'b1;
            if (index_q == last_index) begin
              ready   <= 1'b1;
              state_q <= STARTER;
            end else begin
              index_q <= index_q + 1'b1;
              state_q <= INPUT;
            end
          end
        end
        default: state_q <= STARTER;
      endcase
    end
  end

  // Operands held for the scalar unit, result held for the slot
  always_ff @(posedge CLK) begin
    if (state_q == INPUT && data_in_enable) begin
      data_scalar   <= data_in;
      modulo_scalar <= modulo;
    end
    if (state_q == COMPUTE && ready_scalar) begin
      data_out <= data_out_scalar;
    end
  end

  scalar_mod #(
    .DATA_W (DATA_W)
  ) u_scalar_mod (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start_scalar),
    .modulo   (modulo_scalar),
    .data_in  (data_scalar),
    .ready    (ready_scalar),
    .data_out (data_out_scalar)
  );

endmodule

//--- src/vmod_apb_regs.sv
`timescale 1ns/1ps

module vmod_apb_regs
  import vmod_pkg::*;
#(
  parameter int DATA_W  = 32,
  parameter int INDEX_W = 16
) (
  input  logic               CLK,
  input  logic               RST,
  // APB slave
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  apb_addr_t          paddr,
  input  apb_data_t          pwdata,
  output apb_data_t          prdata,
  output logic               pready,
  output logic               pslverr,
  // Sequencer side
  output logic               start,
  output logic [DATA_W-1:0]  modulo,
  output logic [INDEX_W-1:0] size,
  output logic [DATA_W-1:0]  data_in,
  output logic               data_in_enable,
  input  logic               in_ready,
  input  logic [DATA_W-1:0]  data_out,
  input  logic               data_out_enable,
  output logic               out_ready,
  input  logic               ready
);

  // Address decode
  logic sel_ctrl;
  logic sel_modulo;
  logic sel_size;
  logic sel_data_in;
  logic sel_data_out;
  logic sel_status;
  logic mapped;

  // Transfer qualifiers
  logic access;
  logic xfer_done;
  logic wr_ok;
  logic start_wr;
  logic rd_out;

  // Result slot and status
  logic              slot_full_q;
  logic [DATA_W-1:0] slot_q;
  logic              busy_q;
  logic              done_q;

  assign sel_ctrl     = (paddr == REG_CTRL);
  assign sel_modulo   = (paddr == REG_MODULO);
  assign sel_size     = (paddr == REG_SIZE);
  assign sel_data_in  = (paddr == REG_DATA_IN);
  assign sel_data_out = (paddr == REG_DATA_OUT);
  assign sel_status   = (paddr == REG_STATUS);
  assign mapped       = sel_ctrl | sel_modulo | sel_size | sel_data_in |
                        sel_data_out | sel_status;

  ////////////////////////////////////////////////////////////////////////////
  // APB handshake
  ////////////////////////////////////////////////////////////////////////////

  assign access = psel && penable;

  // Wait states only on element push and result pop
  always_comb begin
    pready = 1'b0;
    if (access) begin
      if (sel_data_in && pwrite) begin
        pready = in_ready;
      end else if (sel_data_out && !pwrite) begin
        pready = slot_full_q;
      end else begin
        pready = 1'b1;
      end
    end
  end

  // Unmapped, or write to a read-only register
  assign pslverr = access && (!mapped || (pwrite && (sel_data_out || sel_status)));

  assign xfer_done = access && pready;
  assign wr_ok     = xfer_done && pwrite && !pslverr;
  assign start_wr  = wr_ok && sel_ctrl && pwdata[CTRL_START_BIT];
  assign rd_out    = xfer_done && !pwrite && sel_data_out;

  // Element handed over in the completing cycle
  assign data_in_enable = wr_ok && sel_data_in;

  assign out_ready = !slot_full_q;

  // Read mux
  always_comb begin
    prdata = '0;
    case (paddr)
      REG_MODULO:   prdata = apb_data_t'(modulo);
      REG_SIZE:     prdata = apb_data_t'(size);
      REG_DATA_IN:  prdata = apb_data_t'(data_in);
      REG_DATA_OUT: prdata = apb_data_t'(slot_q);
      REG_STATUS: begin
        prdata[STATUS_BUSY_BIT] = busy_q;
        prdata[STATUS_DONE_BIT] = done_q;
      end
      default:      prdata = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      start       <= 1'b0;
      modulo      <= '0;
      size        <= '0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      slot_full_q <= 1'b0;
    end else begin
      start <= start_wr;
      if (wr_ok && sel_modulo) begin
        modulo <= pwdata[DATA_W-1:0];
      end
      if (wr_ok && sel_size) begin
        size <= pwdata[INDEX_W-1:0];
      end
      // New run wins over a finishing one
      if (start_wr) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (ready) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      // One-entry slot, filled by the sequencer and emptied by a read
      if (data_out_enable) begin
        slot_full_q <= 1'b1;
      end else if (rd_out) begin
        slot_full_q <= 1'b0;
      end
    end
  end

  // Element taken in the setup phase, stable once the enable fires
  always_ff @(posedge CLK) begin
    if (psel && !penable && pwrite && sel_data_in) begin
      data_in <= pwdata[DATA_W-1:0];
    end
    if (data_out_enable) begin
      slot_q <= data_out;
    end
  end

endmodule

//--- src/vmod_top.sv
`timescale 1ns/1ps

module vmod_top
  import vmod_pkg::*;
#(
  parameter int DATA_W  = 32,
  parameter int INDEX_W = 16
) (
  input  logic      CLK,
  input  logic      RST,
  // APB slave port
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr
);

  // Run control
  logic               start;
  logic               ready;

  // Configuration
  logic [DATA_W-1:0]  modulo;
  logic [INDEX_W-1:0] size;

  // Element in
  logic [DATA_W-1:0]  data_in;
  logic               data_in_enable;
  logic               in_ready;

  // Result out
  logic [DATA_W-1:0]  data_out;
  logic               data_out_enable;
  logic               out_ready;

  vmod_apb_regs #(
    .DATA_W  (DATA_W),
    .INDEX_W (INDEX_W)
  ) u_regs (
    .CLK             (CLK),
    .RST             (RST),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .start           (start),
    .modulo          (modulo),
    .size            (size),
    .data_in         (data_in),
    .data_in_enable  (data_in_enable),
    .in_ready        (in_ready),
    .data_out        (data_out),
    .data_out_enable (data_out_enable),
    .out_ready       (out_ready),
    .ready           (ready)
  );

  // Element-wise modulo sequencer
  vector_mod #(
    .DATA_W  (DATA_W),
    .INDEX_W (INDEX_W)
  ) u_vector_mod (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .ready           (ready),
    .size            (size),
    .modulo          (modulo),
    .data_in         (data_in),
    .data_in_enable  (data_in_enable),
    .in_ready        (in_ready),
    .data_out        (data_out),
    .data_out_enable (data_out_enable),
    .out_ready       (out_ready)
  );

endmodule

//--- sim/vmod_assertions.sv
`timescale 1ns/1ps

module vmod_assertions #(
  parameter int DATA_W = 32
) (
  input logic CLK,
  input logic RST,
  // APB handshake
  input logic pready,
  input logic pslverr,
  // Element and result handshakes
  input logic data_in_enable,
  input logic in_ready,
  input logic data_out_enable,
  input logic out_ready,
  // Scalar unit handshake
  input logic start_scalar,
  input logic ready_scalar
);

  // Failure count, watched from the testbench
  int error_count = 0;

  ////////////////////////////////////////////////////////////////////////////
  // APB side
  ////////////////////////////////////////////////////////////////////////////

  // Error response only in a completing cycle
  a_slverr_with_ready: assert property (@(posedge CLK) disable iff (RST)
    pslverr |-> pready)
    else begin
      error_count++;
      $error("pslverr raised without pready");
    end

  // Quiet bus while in reset
  a_reset_quiet: assert property (@(posedge CLK) RST |-> (!pready && !pslverr))
    else begin
      error_count++;
      $error("pready or pslverr high during reset");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer and scalar unit
  ////////////////////////////////////////////////////////////////////////////

  a_in_enable_ready: assert property (@(posedge CLK) disable iff (RST)
    data_in_enable |-> in_ready)
    else begin
      error_count++;
      $error("data_in_enable while in_ready low");
    end

  // Slot must be empty when a result is pushed
  a_out_enable_ready: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |-> out_ready)
    else begin
      error_count++;
      $error("data_out_enable while out_ready low");
    end

  // Fixed latency of the remainder, both directions
  a_scalar_latency: assert property (@(posedge CLK) disable iff (RST)
    start_scalar |-> ##(DATA_W + 1) ready_scalar)
    else begin
      error_count++;
      $error("ready_scalar missing DATA_W+1 cycles after start_scalar");
    end

  a_scalar_origin: assert property (@(posedge CLK) disable iff (RST)
    ready_scalar |-> $past(start_scalar, DATA_W + 1))
    else begin
      error_count++;
      $error("ready_scalar without start_scalar DATA_W+1 cycles before");
    end

endmodule

bind vmod_top vmod_assertions #(
  .DATA_W (DATA_W)
) u_assertions (
  .CLK             (CLK),
  .RST             (RST),
  .pready          (pready),
  .pslverr         (pslverr),
  .data_in_enable  (data_in_enable),
  .in_ready        (in_ready),
  .data_out_enable (data_out_enable),
  .out_ready       (out_ready),
  .start_scalar    (u_vector_mod.start_scalar),
  .ready_scalar    (u_vector_mod.ready_scalar)
);

//--- sim/vmod_tb.sv
`timescale 1ns/1ps

module vmod_tb
  import vmod_pkg::*;
();

  localparam int DATA_W  = 32;
  localparam int INDEX_W = 16;

  // Elements over all runs, sizes the timeout
  localparam int RANDOM_ELEMS   = 1 + 3 + 8 + 17;
  localparam int SPECIAL_ELEMS  = 4 + 1;
  localparam int BACKPRES_ELEMS = 3;
  localparam int TOTAL_ELEMS    = RANDOM_ELEMS + SPECIAL_ELEMS + BACKPRES_ELEMS;
  localparam int TIMEOUT_CYCLES = TOTAL_ELEMS * (DATA_W + 20) + 2000;
  localparam logic [31:0] SEED  = 32'h9d31_b095;

  logic      CLK;
  logic      RST;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  int cycle_count = 0;

  vmod_top #(
    .DATA_W  (DATA_W),
    .INDEX_W (INDEX_W)
  ) dut (
    .CLK     (CLK),
    .RST     (RST),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string what, input apb_data_t expected,
                                 input apb_data_t got);
    $display("FAIL at %0t ns: %s expected %h got %h", $time, what, expected, got);
    stop_run();
  endtask

  // Cycle budget
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles without finishing", cycle_count);
      stop_run();
    end
  end

  // Bound assertions count their failures
  always @(negedge CLK) begin
    if (dut.u_assertions.error_count != 0) begin
      $display("A protocol assertion inside the DUT failed");
      stop_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////////////////////////////////////////

  // One transfer, outputs sampled at the falling edge where they are stable
  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err, output int waits);
    @(posedge CLK);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    waits   = 0;
    @(negedge CLK);
    while (!pready) begin
      waits++;
      @(negedge CLK);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge CLK);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
    apb_data_t rdata;
    logic      err;
    int        waits;
    apb_access(1'b1, addr, data, rdata, err, waits);
    if (err) begin
      report_mismatch($sformatf("pslverr on write to %h", addr), '0, 32'h1);
    end
  endtask

  task automatic read_check(input apb_addr_t addr, input apb_data_t expected,
                            input string what);
    apb_data_t rdata;
    logic      err;
    int        waits;
    apb_access(1'b0, addr, '0, rdata, err, waits);
    if (err) begin
      report_mismatch($sformatf("pslverr on read of %h", addr), '0, 32'h1);
    end else if (rdata !== expected) begin
      report_mismatch(what, expected, rdata);
    end
  endtask

  // Illegal access must complete with an error response
  task automatic expect_error(input logic write, input apb_addr_t addr);
    apb_data_t rdata;
    logic      err;
    int        waits;
    apb_access(write, addr, 32'hA5A5_5A5A, rdata, err, waits);
    if (err !== 1'b1) begin
      report_mismatch($sformatf("pslverr for access to %h", addr), 32'h1, apb_data_t'(err));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and runs
  ////////////////////////////////////////////////////////////////////////////

  // Zero modulus passes the element through
  function automatic apb_data_t remainder_of(input apb_data_t elem, input apb_data_t modulus);
    if (modulus == '0) begin
      return elem;
    end else begin
      return elem % modulus;
    end
  endfunction

  task automatic run_vector(input apb_data_t modulus, input int size_reg, input int count);
    apb_data_t elem;
    int        i;
    write_reg(REG_MODULO, modulus);
    write_reg(REG_SIZE, apb_data_t'(size_reg));
    write_reg(REG_CTRL, 32'h1);
    // Busy set, done from the last run cleared
    read_check(REG_STATUS, 32'h1, "status after start");
    for (i = 0; i < count; i++) begin
      // All-ones first element, the widest dividend
      elem = (i == 0) ? '1 : $urandom;
      write_reg(REG_DATA_IN, elem);
      read_check(REG_DATA_OUT, remainder_of(elem, modulus), "element result");
    end
    read_check(REG_STATUS, 32'h2, "status after last result");
  endtask

  // Results held back while the host is slow to read
  task automatic run_backpressure(input apb_data_t modulus);
    apb_data_t elem [3];
    apb_data_t rdata;
    logic      err;
    int        waits;
    int        i;
    for (i = 0; i < 3; i++) begin
      elem[i] = $urandom;
    end
    write_reg(REG_MODULO, modulus);
    write_reg(REG_SIZE, 32'd3);
    write_reg(REG_CTRL, 32'h1);
    write_reg(REG_DATA_IN, elem[0]);
    // Next element waits behind the scalar unit
    apb_access(1'b1, REG_DATA_IN, elem[1], rdata, err, waits);
    if (err) begin
      report_mismatch("pslverr on stalled element write", '0, 32'h1);
    end else if (waits == 0) begin
      $display("Element write completed without wait states while the sequencer was busy");
      stop_run();
    end
    // Second result parked in OUTPUT, slot full
    repeat (3 * DATA_W) @(posedge CLK);
    read_check(REG_DATA_OUT, remainder_of(elem[0], modulus), "held result 0");
    read_check(REG_DATA_OUT, remainder_of(elem[1], modulus), "held result 1");
    write_reg(REG_DATA_IN, elem[2]);
    read_check(REG_DATA_OUT, remainder_of(elem[2], modulus), "held result 2");
    read_check(REG_STATUS, 32'h2, "status after back-pressure run");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    apb_data_t modulus;
    void'($urandom(SEED));
    RST     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (5) @(posedge CLK);
    #1;
    RST = 1'b0;

    read_check(REG_STATUS, '0, "status after reset");

    // Edge moduli, then random ones
    run_vector(32'h1, 1, 1);
    run_vector(32'hFFFF_FFFF, 3, 3);
    modulus = $urandom;
    if (modulus == '0) begin
      modulus = 32'h1;
    end
    run_vector(modulus, 8, 8);
    run_vector(apb_data_t'($urandom_range(1000, 2)), 17, 17);

    // Pass-through and zero length
    run_vector('0, 4, 4);
    run_vector(apb_data_t'($urandom_range(5000, 3)), 0, 1);

    run_backpressure(apb_data_t'($urandom_range(200, 7)));

    // Error responses
    expect_error(1'b1, REG_DATA_OUT);
    expect_error(1'b1, REG_STATUS);
    expect_error(1'b0, 8'h18);
    expect_error(1'b1, 8'h40);

    repeat (DATA_W + 4) @(posedge CLK);
    if (dut.u_assertions.error_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Assertion failures found at the end of the run");
      stop_run();
    end
  end

endmodule

//--- vector_mod.f
src/vmod_pkg.sv
src/scalar_mod.sv
src/vector_mod.sv
src/vmod_apb_regs.sv
src/vmod_top.sv
sim/vmod_assertions.sv
sim/vmod_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the vmod testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_TEXT="All checks passed"

# Compile the RTL and the testbench into one executable
verilator --binary --timing --assert -Wno-fatal \
  -f vector_mod.f --top-module vmod_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Run the simulation into the log
./obj_dir/Vvmod_tb +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

# Pass only when the testbench reported it
if grep -q "$PASS_TEXT" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
